//--- Bender.yml
package:
  name: m26_rx

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/m26_rx_pkg.sv
      - hdl/m26_ch_if.sv
      - hdl/m26_rx_ch.sv
      - hdl/m26_rx_merge.sv
      - hdl/m26_rx_ctrl.sv
      - hdl/m26_rx_fifo.sv
      - hdl/m26_rx_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/m26_rx_sva.sv
      - verification/m26_rx_tb.sv

//--- build.f
+incdir+hdl
hdl/m26_rx_pkg.sv
hdl/m26_ch_if.sv
hdl/m26_rx_ch.sv
hdl/m26_rx_merge.sv
hdl/m26_rx_ctrl.sv
hdl/m26_rx_fifo.sv
hdl/m26_rx_core.sv
verification/m26_rx_sva.sv
verification/m26_rx_tb.sv

//--- hdl/m26_ch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface m26_ch_if;
    logic        write;        // one cycle per finished word
    logic        frame_start;  // word is a header
    logic [15:0] data;
    logic        invalid;      // held until next frame start
    logic        invalid_flag; // single pulse

    modport sender (
        output write, frame_start, data, invalid, invalid_flag
    );

    modport receiver (
        input write, frame_start, data, invalid, invalid_flag
    );
endinterface

`default_nettype wire

//--- hdl/m26_rx_cfg.svh
`ifndef M26_RX_CFG_SVH
`define M26_RX_CFG_SVH

// output word framing
`define M26_HEADER 8'h20
`define M26_ID 4'h1

// largest legal data length per lane
`define M26_MAX_LEN 570

// output buffer depth as a power of two
`define M26_FIFO_DEPTH 16

// input delays in CLK_RX cycles
`define M26_LANE0_DLY 1
`define M26_LANE1_DLY 5

`endif

//--- hdl/m26_rx_ch.sv
`timescale 1ns/1ps
`default_nettype none
`include "m26_rx_cfg.svh"

module m26_rx_ch #(
    parameter int LANE_DELAY = 1
) (
    input wire CLK_RX,
    input wire RST_SYNC,
    input wire mkd,
    input wire data_rx,
    m26_ch_if.sender ch
);
    import m26_rx_pkg::*;

    localparam int LEN_W = $clog2(`M26_MAX_LEN + 1);

    logic [LANE_DELAY-1:0] mkd_dly;
    logic [LANE_DELAY-1:0] data_dly;
    logic [3:0]            mkd_sr;
    logic [15:0]           data_sr;
    logic                  mkd_start;
    logic                  word_end;
    logic [3:0]            bit_cnt;
    logic [LEN_W-1:0]      word_cnt;
    logic                  invalid_q;
    logic                  invalid_flag_q;
    m26_ch_state_e         state;

    // lane skew compensation and deserializer
    always_ff @(posedge CLK_RX) begin
        mkd_dly[0] <= mkd;
        data_dly[0] <= data_rx;
        for (int i = 1; i < LANE_DELAY; i++) begin
            mkd_dly[i] <= mkd_dly[i-1];
            data_dly[i] <= data_dly[i-1];
        end
        data_sr <= {data_sr[14:0], data_dly[LANE_DELAY-1]}; // msb first
    end

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            mkd_sr <= '0;
        end else begin
            mkd_sr <= {mkd_sr[2:0], mkd_dly[LANE_DELAY-1]};
        end
    end

    // 4th marker cycle with three header bits already in data_sr
    assign mkd_start = mkd_dly[LANE_DELAY-1] && (mkd_sr[2:0] == 3'b111) && !mkd_sr[3];

    // full word sits in data_sr one cycle after its 16th bit
    assign word_end = (state != ST_IDLE) && (bit_cnt == 4'd0);

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            state <= ST_IDLE;
            bit_cnt <= '0;
            word_cnt <= '0;
            invalid_q <= 1'b0;
            invalid_flag_q <= 1'b0;
        end else begin
            invalid_flag_q <= 1'b0;
            if (state != ST_IDLE)
                bit_cnt <= bit_cnt + 4'd1;
            if (word_end) begin
                case (state)
                    ST_HEADER: state <= ST_COUNT;
                    ST_COUNT:  state <= ST_LENGTH;
                    ST_LENGTH: begin
                        word_cnt <= data_sr[LEN_W-1:0];
                        if (data_sr > `M26_MAX_LEN) begin
                            state <= ST_IDLE; // drop rest of frame
                            invalid_q <= 1'b1;
                            invalid_flag_q <= 1'b1;
                        end else if (data_sr == 16'd0) begin
                            state <= ST_TRAILER;
                        end else begin
                            state <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        word_cnt <= word_cnt - LEN_W'(1);
                        if (word_cnt == LEN_W'(1))
                            state <= ST_TRAILER;
                    end
                    default: state <= ST_IDLE; // trailer done
                endcase
            end
            // marker resyncs from any state
            if (mkd_start) begin
                state <= ST_HEADER;
                bit_cnt <= 4'd4;
                invalid_q <= 1'b0;
            end
        end
    end

    assign ch.write = word_end;
    assign ch.frame_start = (state == ST_HEADER);
    assign ch.data = data_sr;
    assign ch.invalid = invalid_q;
    assign ch.invalid_flag = invalid_flag_q;

endmodule

`default_nettype wire

//--- hdl/m26_rx_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "m26_rx_cfg.svh"

module m26_rx_core (
    input wire CLK_RX,
    input wire RST_SYNC,
    input wire mkd,
    input wire [1:0] data_rx,
    input wire [31:0] timestamp,
    input wire enable,
    input wire timestamp_header,
    input wire fifo_read,
    output wire fifo_empty,
    output wire [31:0] fifo_data,
    output wire lost_error,
    output wire invalid,
    output wire invalid_flag,
    output wire [7:0] lost_count,
    output wire [7:0] invalid_count
);
    import m26_rx_pkg::*;

    wire m26_word_t merge_word;
    wire m26_word_t fifo_word;
    wire            lost;
    wire            fifo_write;
    wire            fifo_full;

    m26_ch_if ch0_if ();
    m26_ch_if ch1_if ();

    // shared marker delayed by each lane
    m26_rx_ch #(
        .LANE_DELAY(`M26_LANE0_DLY)
    ) ch0_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .mkd(mkd),
        .data_rx(data_rx[0]),
        .ch(ch0_if.sender)
    );

    m26_rx_ch #(
        .LANE_DELAY(`M26_LANE1_DLY)
    ) ch1_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .mkd(mkd),
        .data_rx(data_rx[1]),
        .ch(ch1_if.sender)
    );

    m26_rx_merge merge_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .timestamp_header(timestamp_header),
        .timestamp(timestamp),
        .lost(lost),
        .ch0(ch0_if.receiver),
        .ch1(ch1_if.receiver),
        .word(merge_word)
    );

    m26_rx_ctrl ctrl_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .enable(enable),
        .fifo_full(fifo_full),
        .ch0(ch0_if.receiver),
        .ch1(ch1_if.receiver),
        .fifo_write(fifo_write),
        .lost(lost),
        .lost_error(lost_error),
        .invalid(invalid),
        .invalid_flag(invalid_flag),
        .lost_count(lost_count),
        .invalid_count(invalid_count)
    );

    m26_rx_fifo fifo_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .write(fifo_write),
        .word(merge_word),
        .read(fifo_read),
        .full(fifo_full),
        .empty(fifo_empty),
        .rdata(fifo_word)
    );

    assign fifo_data = fifo_word;

endmodule

`default_nettype wire

//--- hdl/m26_rx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module m26_rx_ctrl (
    input wire CLK_RX,
    input wire RST_SYNC,
    input wire enable,
    input wire fifo_full,
    m26_ch_if.receiver ch0,
    m26_ch_if.receiver ch1,
    output logic fifo_write,
    output logic lost,
    output logic lost_error,
    output logic invalid,
    output logic invalid_flag,
    output logic [7:0] lost_count,
    output logic [7:0] invalid_count
);
    logic hdr0;
    logic write_d;
    logic frame_write;
    logic lost_flag;
    logic drop;
    logic inv_frame;
    logic inv_frame_q;

    assign hdr0 = ch0.write && ch0.frame_start;

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            write_d <= 1'b0;
            frame_write <= 1'b0;
        end else begin
            write_d <= ch0.write || ch1.write; // lines up with merge register
            if (hdr0)
                frame_write <= enable; // whole frame on or off
        end
    end

    assign fifo_write = write_d && frame_write;
    assign drop = fifo_write && fifo_full;

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            lost_flag <= 1'b0;
            lost_count <= '0;
        end else begin
            if (drop)
                lost_flag <= 1'b1;
            else if (hdr0)
                lost_flag <= 1'b0;
            if (drop && lost_count != 8'hff)
                lost_count <= lost_count + 8'd1;
        end
    end

    // header word itself already goes out clean
    assign lost = lost_flag && !hdr0;
    assign lost_error = |lost_count;

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            inv_frame <= 1'b0;
            inv_frame_q <= 1'b0;
            invalid_count <= '0;
        end else begin
            if (hdr0)
                inv_frame <= 1'b0;
            else if (ch0.invalid_flag || ch1.invalid_flag)
                inv_frame <= 1'b1;
            inv_frame_q <= inv_frame;
            if (invalid_flag && frame_write && invalid_count != 8'hff)
                invalid_count <= invalid_count + 8'd1;
        end
    end

    assign invalid_flag = inv_frame && !inv_frame_q; // rising edge only
    assign invalid = ch0.invalid || ch1.invalid;

endmodule

`default_nettype wire

//--- hdl/m26_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "m26_rx_cfg.svh"

module m26_rx_fifo (
    input wire CLK_RX,
    input wire RST_SYNC,
    input wire write,
    input wire m26_rx_pkg::m26_word_t word,
    input wire read,
    output logic full,
    output logic empty,
    output m26_rx_pkg::m26_word_t rdata
);
    import m26_rx_pkg::*;

    localparam int DEPTH = `M26_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);

    m26_word_t     mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;
    logic          do_write;
    logic          do_read;

    assign do_write = write && !full; // dropped when full
    assign do_read = read && !empty;

    always_ff @(posedge CLK_RX) begin
        if (do_write)
            mem[wr_ptr] <= word;
    end

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
        end else begin
            if (do_write)
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            if (do_read)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign full = (level == (AW + 1)'(DEPTH));
    assign empty = (level == '0);
    assign rdata = mem[rd_ptr]; // show-ahead

endmodule

`default_nettype wire

//--- hdl/m26_rx_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "m26_rx_cfg.svh"

module m26_rx_merge (
    input wire CLK_RX,
    input wire RST_SYNC,
    input wire timestamp_header,
    input wire [31:0] timestamp,
    input wire lost,
    m26_ch_if.receiver ch0,
    m26_ch_if.receiver ch1,
    output m26_rx_pkg::m26_word_t word
);
    logic [15:0] ts_hi;
    logic [15:0] data_q;
    logic        frame_start_q;
    logic        lost_q;
    logic        hdr0;
    logic        hdr1;
    logic        any_write;

    assign hdr0 = ch0.write && ch0.frame_start;
    assign hdr1 = ch1.write && ch1.frame_start;
    assign any_write = ch0.write || ch1.write;

    always_ff @(posedge CLK_RX) begin
        if (hdr0)
            ts_hi <= timestamp[31:16]; // for the lane-1 header
        if (timestamp_header && hdr0)
            data_q <= timestamp[15:0];
        else if (timestamp_header && hdr1)
            data_q <= ts_hi;
        else if (ch0.write)
            data_q <= ch0.data;
        else if (ch1.write)
            data_q <= ch1.data;
    end

    always_ff @(posedge CLK_RX) begin
        if (RST_SYNC) begin
            frame_start_q <= 1'b0;
            lost_q <= 1'b0;
        end else if (any_write) begin
            frame_start_q <= hdr0; // lane-1 header does not count
            lost_q <= lost;
        end
    end

    always_comb begin
        word.header = `M26_HEADER;
        word.id = `M26_ID;
        word.zero = 2'b00;
        word.lost = lost_q;
        word.frame_start = frame_start_q;
        word.data = data_q;
    end

endmodule

`default_nettype wire

//--- hdl/m26_rx_pkg.sv
`default_nettype none

package m26_rx_pkg;

    // output FIFO word
    typedef struct packed {
        logic [7:0]  header;
        logic [3:0]  id;
        logic [1:0]  zero;
        logic        lost;        // words dropped earlier in this frame
        logic        frame_start; // lane-0 header
        logic [15:0] data;
    } m26_word_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_COUNT,
        ST_LENGTH,
        ST_DATA,
        ST_TRAILER
    } m26_ch_state_e;

endpackage

`default_nettype wire

//--- verification/m26_rx_sva.sv
`timescale 1ns/1ps
`default_nettype none

module m26_rx_sva (
    input wire CLK_RX,
    input wire RST_SYNC,
    input wire write,
    input var m26_rx_pkg::m26_ch_state_e state,
    input wire full,
    input wire empty
);
    import m26_rx_pkg::*;

    // lane receiver strobes only inside a frame
    write_in_frame: assert property (@(posedge CLK_RX) disable iff (RST_SYNC)
        write |-> state != ST_IDLE)
        else begin
            $error("word strobe while lane receiver idle");
            m26_rx_tb.sva_fail_count++;
        end

    full_xor_empty: assert property (@(posedge CLK_RX) disable iff (RST_SYNC)
        !(full && empty))
        else begin
            $error("fifo full and empty at once");
            m26_rx_tb.sva_fail_count++;
        end

endmodule

`default_nettype wire

//--- verification/m26_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "m26_rx_cfg.svh"

module m26_rx_tb;
    import m26_rx_pkg::*;

    localparam int SEED = 91770;
    localparam int GAP = 12;             // idle cycles after each frame
    localparam int NO_LIMIT = 100000;
    localparam int FRAME_BITS = 68 * 16; // longer lane of each of the nine frames
    localparam int TS_CHANGE = 20;       // between the lane-0 and lane-1 header strobes

    logic        CLK_RX = 1'b0;
    logic        RST_SYNC;
    logic        mkd;
    logic [1:0]  data_rx;
    logic [31:0] timestamp;
    logic        enable;
    logic        timestamp_header;
    logic        fifo_read;
    wire         fifo_empty;
    wire  [31:0] fifo_data;
    wire         lost_error;
    wire         invalid;
    wire         invalid_flag;
    wire  [7:0]  lost_count;
    wire  [7:0]  invalid_count;

    logic [15:0] lane0_q [$];
    logic [15:0] lane1_q [$];
    m26_word_t   model_q [$];
    int          flag_pulses = 0;
    int          sva_fail_count = 0;
    int          frame_no = 0;

    m26_rx_core dut_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .mkd(mkd),
        .data_rx(data_rx),
        .timestamp(timestamp),
        .enable(enable),
        .timestamp_header(timestamp_header),
        .fifo_read(fifo_read),
        .fifo_empty(fifo_empty),
        .fifo_data(fifo_data),
        .lost_error(lost_error),
        .invalid(invalid),
        .invalid_flag(invalid_flag),
        .lost_count(lost_count),
        .invalid_count(invalid_count)
    );

    bind m26_rx_ch m26_rx_sva ch_sva_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .write(word_end),
        .state(state),
        .full(1'b0),
        .empty(1'b0)
    );

    bind m26_rx_fifo m26_rx_sva fifo_sva_i (
        .CLK_RX(CLK_RX),
        .RST_SYNC(RST_SYNC),
        .write(1'b0),
        .state(m26_rx_pkg::ST_IDLE),
        .full(full),
        .empty(empty)
    );

    always #5 CLK_RX = ~CLK_RX;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    function automatic int lane_len(input int lane);
        return (lane == 0) ? lane0_q.size() : lane1_q.size();
    endfunction

    function automatic logic [15:0] lane_word(input int lane, input int k);
        if (k >= lane_len(lane))
            return 16'h0000; // lane idles
        return (lane == 0) ? lane0_q[k] : lane1_q[k];
    endfunction

    // bad length ends the lane's frame after the length word
    function automatic int lane_sent(input int lane);
        if (lane_len(lane) > 2 && lane_word(lane, 2) > `M26_MAX_LEN)
            return 3;
        return lane_len(lane);
    endfunction

    function automatic void push_word(input int lane, input logic [15:0] w);
        if (lane == 0)
            lane0_q.push_back(w);
        else
            lane1_q.push_back(w);
    endfunction

    task automatic make_frame(input int len0, input int len1);
        int len;
        lane0_q.delete();
        lane1_q.delete();
        for (int lane = 0; lane < 2; lane++) begin
            len = (lane == 0) ? len0 : len1;
            push_word(lane, 16'h5555);
            push_word(lane, frame_no[15:0]);
            push_word(lane, len[15:0]);
            if (len <= `M26_MAX_LEN) begin
                for (int i = 0; i < len; i++)
                    push_word(lane, 16'($urandom()));
                push_word(lane, 16'haaaa);
            end
        end
        frame_no++;
    endtask

    // expected FIFO words in strobe order as lane 1 trails lane 0
    task automatic expect_frame(input logic ts_hdr, input logic [31:0] ts, input int keep);
        m26_word_t w;
        int n;
        int kept;
        n = (lane_sent(0) > lane_sent(1)) ? lane_sent(0) : lane_sent(1);
        kept = 0;
        for (int k = 0; k < n; k++) begin
            for (int lane = 0; lane < 2; lane++) begin
                if (k < lane_sent(lane) && kept < keep) begin
                    w.header = `M26_HEADER;
                    w.id = `M26_ID;
                    w.zero = 2'b00;
                    w.lost = 1'b0;
                    w.frame_start = (lane == 0) && (k == 0);
                    w.data = lane_word(lane, k);
                    if (ts_hdr && k == 0)
                        w.data = (lane == 0) ? ts[15:0] : ts[31:16];
                    model_q.push_back(w);
                    kept++;
                end
            end
        end
    endtask

    task automatic drive_frame();
        logic [15:0] w0;
        logic [15:0] w1;
        int n;
        n = (lane0_q.size() > lane1_q.size()) ? lane0_q.size() : lane1_q.size();
        for (int k = 0; k < n; k++) begin
            w0 = lane_word(0, k);
            w1 = lane_word(1, k);
            for (int b = 15; b >= 0; b--) begin
                @(negedge CLK_RX);
                mkd = (k == 0) && (b >= 12); // marker over the first four header bits
                data_rx[0] = w0[b];
                data_rx[1] = w1[b];
            end
        end
        repeat (GAP) begin
            @(negedge CLK_RX);
            mkd = 1'b0;
            data_rx = 2'b00;
        end
    endtask

    task automatic drain_check();
        m26_word_t exp;
        int wait_cnt;
        while (model_q.size() > 0) begin
            exp = model_q.pop_front();
            wait_cnt = 0;
            while (fifo_empty) begin
                @(negedge CLK_RX);
                wait_cnt++;
                if (wait_cnt > 50)
                    stop_run("timeout waiting for a word in the FIFO");
            end
            compare("fifo_data", fifo_data, exp);
            fifo_read = 1'b1;
            @(negedge CLK_RX);
            fifo_read = 1'b0;
        end
        compare("fifo_empty", fifo_empty, 1);
    endtask

    task automatic good_frame();
        make_frame(3, 3);
        expect_frame(1'b0, 32'h0, NO_LIMIT);
        drive_frame();
        drain_check();
    endtask

    task automatic frames_in_order();
        enable = 1'b1;
        repeat (2) good_frame();
    endtask

    task automatic timestamp_swap();
        logic [31:0] ts;
        ts = $urandom();
        timestamp = ts;
        timestamp_header = 1'b1;
        make_frame(3, 3);
        expect_frame(1'b1, ts, NO_LIMIT);
        fork
            drive_frame();
            begin
                repeat (TS_CHANGE) @(negedge CLK_RX);
                timestamp = ~ts; // lane-0 header already taken
            end
        join
        drain_check();
        timestamp_header = 1'b0;
    endtask

    task automatic enable_gating();
        enable = 1'b0;
        make_frame(3, 3);
        fork
            drive_frame();
            begin
                repeat (48) @(negedge CLK_RX);
                enable = 1'b1; // too late for this frame
            end
        join
        compare("fifo_empty", fifo_empty, 1);
        good_frame();
    endtask

    task automatic bad_length_frame();
        int count0;
        count0 = invalid_count;
        flag_pulses = 0;
        make_frame(3, 600);
        expect_frame(1'b0, 32'h0, NO_LIMIT);
        drive_frame();
        compare("invalid", invalid, 1);
        compare("invalid_flag pulses", flag_pulses, 1);
        compare("invalid_count", invalid_count, (count0 + 1) & 8'hff);
        drain_check();
        good_frame();
        compare("invalid", invalid, 0);
        compare("invalid_flag pulses", flag_pulses, 1);
    endtask

    task automatic fifo_overflow();
        int count0;
        int sent;
        count0 = lost_count;
        make_frame(8, 8);
        sent = lane_sent(0) + lane_sent(1);
        expect_frame(1'b0, 32'h0, `M26_FIFO_DEPTH);
        drive_frame();
        compare("lost_count", lost_count, count0 + sent - `M26_FIFO_DEPTH);
        compare("lost_error", lost_error, 1);
        drain_check();
        good_frame(); // lost bit clear again
    endtask

    always @(negedge CLK_RX) begin
        if (invalid_flag === 1'b1)
            flag_pulses++;
        if (sva_fail_count != 0)
            stop_run("assertion failed inside the DUT");
    end

    initial begin
        repeat (FRAME_BITS * 2 + 500) @(posedge CLK_RX);
        stop_run("watchdog timeout, tests did not finish");
    end

    initial begin
        void'($urandom(SEED));
        RST_SYNC = 1'b1;
        mkd = 1'b0;
        data_rx = 2'b00;
        timestamp = 32'h0;
        enable = 1'b0;
        timestamp_header = 1'b0;
        fifo_read = 1'b0;
        repeat (5) @(negedge CLK_RX);
        RST_SYNC = 1'b0;
        compare("fifo_empty", fifo_empty, 1);
        compare("lost_error", lost_error, 0);
        compare("invalid", invalid, 0);
        compare("invalid_flag", invalid_flag, 0);
        compare("lost_count", lost_count, 0);
        compare("invalid_count", invalid_count, 0);
        frames_in_order();
        timestamp_swap();
        enable_gating();
        bad_length_frame();
        fifo_overflow();
        if (sva_fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_run("assertion failures seen in the DUT");
        end
    end

endmodule

`default_nettype wire
